//--- sim.f
+incdir+hw
hw/exec_pkg.sv
hw/credit_queue.sv
hw/operand_stage.sv
hw/alu.sv
hw/alu_stage.sv
hw/exec_top.sv
test/tb_exec_top.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --timescale 1ns/100ps --top-module tb_exec_top \
    -f sim.f -o tb_exec_top > build.log 2>&1 &&
    ./obj_dir/tb_exec_top > sim.log 2>&1 ||
    { echo "build or simulation did not complete"; exit 1; }
grep -q '^\*\*\* PASSED \*\*\*$' sim.log && echo "simulation passed" ||
    { echo "simulation failed, see sim.log"; exit 1; }

//--- test/tb_exec_top.sv
`timescale 1ns/100ps
`include "exec_config.svh"

module tb_exec_top;

    localparam logic [31:0] SEED = 32'hb3945f88;
    localparam int TIMEOUT_CYCLES = 400;

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic                   in_valid;
    exec_pkg::exec_uop_t    in_uop;
    logic                   in_credit;
    logic                   out_valid;
    exec_pkg::exec_result_t out_result;
    logic                   out_credit = 1'b0;

    exec_pkg::exec_result_t exp_q[$]; // expected results in issue order.
    string                  name_q[$];
    logic [31:0]            prod_rng = SEED;
    logic [31:0]            cons_rng = {SEED[15:0], SEED[31:16]};
    int                     prod_credits = `EXEC_IN_DEPTH;
    int                     cons_credits = `EXEC_CONS_CREDITS; // mirror of out_queue credits.
    int                     accepted = 0;
    int                     in_pulses = 0;
    int                     out_total = 0;
    int                     result_errors = 0;
    int                     count_errors = 0;
    int                     other_errors = 0;
    int                     cons_mode = 0; // 0 idle, 1 withheld, 2 greedy, 3 bursts.
    int                     cons_mode_now;
    int                     phase_left = 0;
    logic                   in_burst = 1'b0;
    logic                   room;

    exec_top DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_uop     (in_uop),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_result (out_result),
        .out_credit (out_credit)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] prod_rand();
        prod_rng = lcg_next(prod_rng);
        return prod_rng ^ (prod_rng >> 15); // folds the better high bits down.
    endfunction

    // reference model, written from the execute rules.
    function automatic exec_pkg::exec_result_t expect_result(input exec_pkg::exec_uop_t u);
        exec_pkg::exec_result_t r;
        logic [31:0]            imm;
        logic [31:0]            a;
        logic [31:0]            b;
        logic [31:0]            y;
        logic signed [31:0]     sa;
        logic signed [31:0]     sb;
        logic [4:0]             sh;
        case (u.imm_sel)
            exec_pkg::imm_i12: imm = u.imm[11] ? {20'hfffff, u.imm[11:0]} : {20'h0, u.imm[11:0]};
            exec_pkg::imm_u20: imm = {u.imm[19:0], 12'h000};
            exec_pkg::imm_j20: begin
                imm = u.imm[19] ? (32'hfff00000 | {12'd0, u.imm[19:0]}) : {12'd0, u.imm[19:0]};
                imm = imm << 1;
            end
            default:           imm = u.imm & 32'h0000001f;
        endcase
        a = (u.src1_sel == exec_pkg::src1_reg) ? u.rs1_value :
            (u.src1_sel == exec_pkg::src1_pc) ? u.pc : 32'd0;
        case (u.src2_sel)
            exec_pkg::src2_imm: b = imm;
            exec_pkg::src2_rs2: b = u.rs2_value;
            exec_pkg::src2_csr: b = u.csr_value;
            default:            b = 32'd0;
        endcase
        sa = a;
        sb = b;
        sh = b[4:0];
        case (u.alu_op)
            exec_pkg::alu_add:  y = a + b;
            exec_pkg::alu_sub:  y = a - b;
            exec_pkg::alu_sll:  y = a << sh;
            exec_pkg::alu_slt:  y = (sa < sb) ? 32'd1 : 32'd0;
            exec_pkg::alu_sltu: y = (a < b) ? 32'd1 : 32'd0;
            exec_pkg::alu_xor:  y = a ^ b;
            exec_pkg::alu_srl:  y = a >> sh;
            exec_pkg::alu_sra: begin
                y = a >> sh;
                if (a[31]) y = y | ~(32'hffffffff >> sh); // refill with the sign.
            end
            exec_pkg::alu_or:   y = a | b;
            exec_pkg::alu_and:  y = a & b;
            default:            y = 32'd0;
        endcase
        y[0]         = y[0] ^ u.inv;
        r.result     = y;
        r.pc         = u.pc;
        r.store_data = u.rs2_value;
        r.csr_value  = u.csr_value;
        r.rd         = u.rd;
        r.csr_wen    = u.csr_wen;
        r.reg_wen    = u.reg_wen;
        r.mem_wen    = u.mem_wen;
        r.mem_ren    = u.mem_ren;
        return r;
    endfunction

    task automatic check_result(input string name, input exec_pkg::exec_result_t expected,
                                input exec_pkg::exec_result_t actual);
        if (actual !== expected) begin
            result_errors++;
            $display("Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            count_errors++;
            $display("Error %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic make_random_uop(output exec_pkg::exec_uop_t u);
        logic [31:0] r;
        logic [31:0] s;
        r           = prod_rand();
        s           = prod_rand();
        u.pc        = prod_rand() & 32'hfffffffc;
        u.imm       = prod_rand();
        u.rs1_value = prod_rand();
        case (s[1:0])
            2'd0:    u.rs2_value = u.rs1_value; // equal operands for the compares.
            2'd1:    u.rs2_value = {27'd0, s[31:27]};
            default: u.rs2_value = prod_rand();
        endcase
        u.csr_value = prod_rand();
        u.rd        = r[13:9];
        u.csr_wen   = r[8:5];
        u.reg_wen   = r[16];
        u.mem_wen   = r[15];
        u.mem_ren   = r[14];
        u.inv       = r[17];
        u.imm_sel   = exec_pkg::imm_sel_e'(r[23:22]);
        u.src1_sel  = exec_pkg::src1_sel_e'(r[21:20]);
        u.src2_sel  = exec_pkg::src2_sel_e'(r[19:18]);
        u.alu_op    = exec_pkg::alu_op_e'(4'(r[31:24] % 8'd11));
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic send_uop(input exec_pkg::exec_uop_t u, input exec_pkg::exec_result_t e,
                            input string name);
        int waited;
        waited = 0;
        while (prod_credits == 0 && waited < TIMEOUT_CYCLES) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (prod_credits == 0) begin
            other_errors++;
            $display("timeout: producer got no credit back for %s", name);
        end else begin
            in_valid = 1'b1;
            in_uop   = u;
            exp_q.push_back(e);
            name_q.push_back(name);
            accepted++;
            @(posedge clk);
            #1;
            in_valid = 1'b0;
        end
    endtask

    task automatic directed_imm(input logic [31:0] raw, input logic [31:0] i12,
                                input logic [31:0] u20, input logic [31:0] j20,
                                input logic [31:0] u5);
        exec_pkg::exec_uop_t    u;
        exec_pkg::exec_result_t e;
        for (int sel = 0; sel < 4; sel++) begin
            make_random_uop(u);
            u.imm      = raw;
            u.imm_sel  = exec_pkg::imm_sel_e'(2'(sel));
            u.src1_sel = exec_pkg::src1_zero;
            u.src2_sel = exec_pkg::src2_imm;
            u.alu_op   = exec_pkg::alu_add;
            u.inv      = 1'b0;
            e          = expect_result(u);
            e.result   = (sel == 0) ? i12 : (sel == 1) ? u20 : (sel == 2) ? j20 : u5;
            send_uop(u, e, (sel == 0) ? "imm_i12" : (sel == 1) ? "imm_u20" :
                           (sel == 2) ? "imm_j20" : "imm_u5");
        end
    endtask

    task automatic wait_drain(input string what);
        int waited;
        waited = 0;
        while ((exp_q.size() != 0 || prod_credits != `EXEC_IN_DEPTH) &&
               waited < TIMEOUT_CYCLES) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (exp_q.size() != 0 || prod_credits != `EXEC_IN_DEPTH) begin
            other_errors++;
            $display("timeout: the DUT did not drain after %s", what);
        end
        idle_cycles(3);
    endtask

    // consumer grants credits; it never hands out more than out_queue can hold.
    always @(posedge clk) begin
        cons_mode_now = cons_mode;
        #1;
        room = (cons_credits - int'(out_valid)) < `EXEC_CONS_CREDITS;
        if (cons_mode_now == 3) begin
            if (phase_left == 0) begin
                cons_rng   = lcg_next(cons_rng);
                in_burst   = cons_rng[31];
                phase_left = 1 + int'(cons_rng[30:27]);
            end
            phase_left--;
            out_credit = in_burst && room;
        end else begin
            out_credit = (cons_mode_now == 2) && room;
        end
    end

    always @(negedge clk) begin
        if (rst_n) begin
            if (in_valid) prod_credits--;
            if (in_credit) begin
                prod_credits++;
                in_pulses++;
            end
            if (out_valid) begin
                out_total++;
                if (cons_credits == 0) begin
                    other_errors++;
                    $display("out_valid was raised with no consumer credit left");
                end else begin
                    cons_credits--;
                end
                if (exp_q.size() == 0) begin
                    other_errors++;
                    $display("a result came out with none expected");
                end else begin
                    check_result(name_q.pop_front(), exp_q.pop_front(), out_result);
                end
            end
            if (out_credit) cons_credits++;
        end
    end

    initial begin
        exec_pkg::exec_uop_t u;
        logic [31:0]         r;
        int                  snap_out;
        int                  snap_pulses;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_uop   = '0;
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            #1;
            check_count("reset_out_valid", 0, int'(out_valid));
            check_count("reset_in_credit", 0, int'(in_credit));
        end
        rst_n = 1'b1;
        for (int i = 0; i < 3; i++) begin
            @(negedge clk);
            check_count("idle_out_valid", 0, int'(out_valid));
            check_count("idle_in_credit", 0, int'(in_credit));
        end
        @(posedge clk);
        #1;
        cons_mode = 3;
        directed_imm(32'h000ff801, 32'hfffff801, 32'hff801000, 32'hfffff002, 32'h00000001);
        directed_imm(32'h00012345, 32'h00000345, 32'h12345000, 32'h0002468a, 32'h00000005);
        for (int i = 0; i < 300; i++) begin
            make_random_uop(u);
            send_uop(u, expect_result(u), "random");
            r = prod_rand();
            if (r[31:29] == 3'd0) idle_cycles(int'(r[3:0]));
        end
        cons_mode = 2;
        wait_drain("random traffic");
        check_count("in_credit_pulses", accepted, in_pulses);
        check_count("producer_credits", `EXEC_IN_DEPTH, prod_credits);

        // withhold grants until both queues back up.
        cons_mode = 1;
        snap_out  = out_total;
        for (int i = 0; i < 8; i++) begin
            make_random_uop(u);
            send_uop(u, expect_result(u), "withheld");
        end
        idle_cycles(20);
        snap_pulses = in_pulses;
        idle_cycles(10);
        check_count("withheld_out", `EXEC_CONS_CREDITS, out_total - snap_out);
        check_count("withheld_credits", 0, cons_credits);
        check_count("stalled_in_credit", 0, in_pulses - snap_pulses);
        cons_mode = 2;
        wait_drain("withheld traffic");
        check_count("lost_results", 0, exp_q.size());
        check_count("delivered", accepted, out_total);
        check_count("final_in_credit_pulses", accepted, in_pulses);
        check_count("final_producer_credits", `EXEC_IN_DEPTH, prod_credits);

        $display("errors: result %0d, count %0d, other %0d",
                 result_errors, count_errors, other_errors);
        if (result_errors + count_errors + other_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- hw/exec_top.sv
`timescale 1ns/100ps
`include "exec_config.svh"

module exec_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  exec_pkg::exec_uop_t    in_uop,
    output logic                   in_credit,
    output logic                   out_valid,
    output exec_pkg::exec_result_t out_result,
    input  logic                   out_credit
);

    logic                   iq_valid;
    exec_pkg::exec_uop_t    iq_uop;
    logic                   op_valid;
    exec_pkg::operands_t    op_ops;
    logic                   alu_valid;
    exec_pkg::exec_result_t alu_result;
    logic                   oq_credit;

    // counts free output slots, so the stages never need to stall.
    credit_queue #(
        .T            (exec_pkg::exec_uop_t),
        .DEPTH        (`EXEC_IN_DEPTH),
        .INIT_CREDITS (`EXEC_OUT_DEPTH)
    ) in_queue (
        .clk           (clk),
        .rst_n         (rst_n),
        .wr_valid      (in_valid),
        .wr_data       (in_uop),
        .send_valid    (iq_valid),
        .send_data     (iq_uop),
        .credit_in     (oq_credit),
        .credit_return (in_credit)
    );

    operand_stage u_operand_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (iq_valid),
        .in_uop    (iq_uop),
        .out_valid (op_valid),
        .out_ops   (op_ops)
    );

    alu_stage u_alu_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (op_valid),
        .in_ops     (op_ops),
        .out_valid  (alu_valid),
        .out_result (alu_result)
    );

    credit_queue #(
        .T            (exec_pkg::exec_result_t),
        .DEPTH        (`EXEC_OUT_DEPTH),
        .INIT_CREDITS (`EXEC_CONS_CREDITS)
    ) out_queue (
        .clk           (clk),
        .rst_n         (rst_n),
        .wr_valid      (alu_valid),
        .wr_data       (alu_result),
        .send_valid    (out_valid),
        .send_data     (out_result),
        .credit_in     (out_credit),
        .credit_return (oq_credit)  // frees a slot for in_queue.
    );

endmodule

//--- hw/alu_stage.sv
`timescale 1ns/100ps
`include "exec_config.svh"

module alu_stage (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  exec_pkg::operands_t    in_ops,
    output logic                   out_valid,
    output exec_pkg::exec_result_t out_result
);

    logic [`EXEC_XLEN-1:0]  alu_y;
    logic [`EXEC_XLEN-1:0]  result;
    exec_pkg::exec_result_t result_d;

    alu u_alu (
        .a  (in_ops.src1),
        .b  (in_ops.src2),
        .op (in_ops.alu_op),
        .y  (alu_y)
    );

    // sge and sgeu come out of slt and sltu this way.
    assign result = alu_y ^ {{(`EXEC_XLEN-1){1'b0}}, in_ops.inv};

    always_comb begin
        result_d.result     = result;
        result_d.pc         = in_ops.pc;
        result_d.store_data = in_ops.store_data;
        result_d.csr_value  = in_ops.csr_value;
        result_d.rd         = in_ops.rd;
        result_d.csr_wen    = in_ops.csr_wen;
        result_d.reg_wen    = in_ops.reg_wen;
        result_d.mem_wen    = in_ops.mem_wen;
        result_d.mem_ren    = in_ops.mem_ren;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_result <= result_d;
        end
    end

endmodule

//--- hw/alu.sv
`timescale 1ns/100ps
`include "exec_config.svh"

module alu (
    input  logic [`EXEC_XLEN-1:0] a,
    input  logic [`EXEC_XLEN-1:0] b,
    input  exec_pkg::alu_op_e     op,
    output logic [`EXEC_XLEN-1:0] y
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b[4:0]; // only the low bits count for shifts.
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            exec_pkg::alu_add: begin
                y = a + b;
            end
            exec_pkg::alu_sub: begin
                y = a - b;
            end
            exec_pkg::alu_sll: begin
                y = a << shamt;
            end
            exec_pkg::alu_slt: begin
                y = {{(`EXEC_XLEN-1){1'b0}}, lt_signed};
            end
            exec_pkg::alu_sltu: begin
                y = {{(`EXEC_XLEN-1){1'b0}}, lt_unsigned};
            end
            exec_pkg::alu_xor: begin
                y = a ^ b;
            end
            exec_pkg::alu_srl: begin
                y = a >> shamt;
            end
            exec_pkg::alu_sra: begin
                y = $unsigned($signed(a) >>> shamt);
            end
            exec_pkg::alu_or: begin
                y = a | b;
            end
            exec_pkg::alu_and: begin
                y = a & b;
            end
            default: begin
                y = '0; // unused op codes.
            end
        endcase
    end

endmodule

//--- hw/operand_stage.sv
`timescale 1ns/100ps
`include "exec_config.svh"

module operand_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    input  exec_pkg::exec_uop_t in_uop,
    output logic                out_valid,
    output exec_pkg::operands_t out_ops
);

    logic [`EXEC_XLEN-1:0] imm_val;
    logic [`EXEC_XLEN-1:0] src1;
    logic [`EXEC_XLEN-1:0] src2;
    exec_pkg::operands_t   ops_d;

    always_comb begin
        case (in_uop.imm_sel)
            exec_pkg::imm_i12: imm_val = {{(`EXEC_XLEN-12){in_uop.imm[11]}}, in_uop.imm[11:0]};
            exec_pkg::imm_u20: imm_val = `EXEC_XLEN'({in_uop.imm[19:0], 12'd0});
            exec_pkg::imm_j20: begin
                imm_val = {{(`EXEC_XLEN-21){in_uop.imm[19]}}, in_uop.imm[19:0], 1'b0};
            end
            exec_pkg::imm_u5:  imm_val = {{(`EXEC_XLEN-5){1'b0}}, in_uop.imm[4:0]};
            default:           imm_val = '0;
        endcase
    end

    always_comb begin
        case (in_uop.src1_sel)
            exec_pkg::src1_reg: src1 = in_uop.rs1_value;
            exec_pkg::src1_pc:  src1 = in_uop.pc;
            default:            src1 = '0; // zero, and the spare code.
        endcase
    end

    always_comb begin
        case (in_uop.src2_sel)
            exec_pkg::src2_imm: src2 = imm_val;
            exec_pkg::src2_rs2: src2 = in_uop.rs2_value;
            exec_pkg::src2_csr: src2 = in_uop.csr_value;
            default:            src2 = '0;
        endcase
    end

    always_comb begin
        ops_d.src1       = src1;
        ops_d.src2       = src2;
        ops_d.alu_op     = in_uop.alu_op;
        ops_d.inv        = in_uop.inv;
        ops_d.pc         = in_uop.pc;
        ops_d.store_data = in_uop.rs2_value; // stores always take rs2.
        ops_d.csr_value  = in_uop.csr_value;
        ops_d.rd         = in_uop.rd;
        ops_d.csr_wen    = in_uop.csr_wen;
        ops_d.reg_wen    = in_uop.reg_wen;
        ops_d.mem_wen    = in_uop.mem_wen;
        ops_d.mem_ren    = in_uop.mem_ren;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_ops <= ops_d;
        end
    end

    // the queue must never hand over a micro-op with an undriven immediate form.
    a_imm_sel_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        in_valid |-> !$isunknown(in_uop.imm_sel)
    ) else $error("operand_stage: unknown imm_sel on a valid micro-op");

endmodule

//--- hw/credit_queue.sv
`timescale 1ns/100ps

module credit_queue #(
    parameter type T            = logic [31:0],
    parameter int  DEPTH        = 4,
    parameter int  INIT_CREDITS = 4
) (
    input  logic clk,
    input  logic rst_n,
    input  logic wr_valid,
    input  T     wr_data,
    output logic send_valid,
    output T     send_data,
    input  logic credit_in,
    output logic credit_return
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam int CRD_W = $clog2(INIT_CREDITS + 2); // one spare so an overrun is visible.

    T                 mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CRD_W-1:0] credits;
    logic             full;
    logic             wr_en;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] nxt;
        nxt = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
        return nxt;
    endfunction

    assign full  = (count == CNT_W'(DEPTH));
    assign wr_en = wr_valid && !full;

    // issue only when something is held and downstream has room.
    assign send_valid    = (count != '0) && (credits != '0);
    assign send_data     = mem[rd_ptr];
    assign credit_return = send_valid; // the freed slot goes back upstream.

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            credits <= CRD_W'(INIT_CREDITS);
        end else begin
            if (wr_en) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (send_valid) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count <= count + CNT_W'(wr_en) - CNT_W'(send_valid);
            // a grant in the same cycle as a send cancels out.
            credits <= credits - CRD_W'(send_valid) + CRD_W'(credit_in);
        end
    end

    // upstream must hold back until a credit came back for this slot.
    a_no_write_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        wr_valid |-> !full
    ) else $error("credit_queue: write while full");

    // downstream returns no more credits than it was given.
    a_credit_bound: assert property (
        @(posedge clk) disable iff (!rst_n)
        credits <= CRD_W'(INIT_CREDITS)
    ) else $error("credit_queue: credit count above its initial value");

endmodule

//--- hw/exec_pkg.sv
`include "exec_config.svh"

package exec_pkg;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_sll  = 4'd2,
        alu_slt  = 4'd3,
        alu_sltu = 4'd4,
        alu_xor  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_or   = 4'd8,
        alu_and  = 4'd9
    } alu_op_e;

    typedef enum logic [1:0] {
        imm_i12 = 2'd0, // sign-extended 12 bit.
        imm_u20 = 2'd1, // upper 20 bit.
        imm_j20 = 2'd2, // jump offset, shifted by one.
        imm_u5  = 2'd3  // zero-extended 5 bit.
    } imm_sel_e;

    typedef enum logic [1:0] {
        src1_reg  = 2'd0,
        src1_pc   = 2'd1,
        src1_zero = 2'd2
    } src1_sel_e;

    typedef enum logic [1:0] {
        src2_imm  = 2'd0,
        src2_rs2  = 2'd1,
        src2_csr  = 2'd2,
        src2_zero = 2'd3
    } src2_sel_e;

    // decoded micro-op with its register operands.
    typedef struct packed {
        logic [`EXEC_XLEN-1:0] pc;
        logic [`EXEC_XLEN-1:0] imm;
        logic [`EXEC_XLEN-1:0] rs1_value;
        logic [`EXEC_XLEN-1:0] rs2_value;
        logic [`EXEC_XLEN-1:0] csr_value;
        logic [4:0]            rd;
        logic [3:0]            csr_wen;
        logic                  reg_wen;
        logic                  mem_wen;
        logic                  mem_ren;
        logic                  inv;
        imm_sel_e              imm_sel;
        src1_sel_e             src1_sel;
        src2_sel_e             src2_sel;
        alu_op_e               alu_op;
    } exec_uop_t;

    // what the memory stage receives.
    typedef struct packed {
        logic [`EXEC_XLEN-1:0] result;
        logic [`EXEC_XLEN-1:0] pc;
        logic [`EXEC_XLEN-1:0] store_data;
        logic [`EXEC_XLEN-1:0] csr_value;
        logic [4:0]            rd;
        logic [3:0]            csr_wen;
        logic                  reg_wen;
        logic                  mem_wen;
        logic                  mem_ren;
    } exec_result_t;

    typedef struct packed {
        logic [`EXEC_XLEN-1:0] src1;
        logic [`EXEC_XLEN-1:0] src2;
        alu_op_e               alu_op;
        logic                  inv;
        logic [`EXEC_XLEN-1:0] pc;
        logic [`EXEC_XLEN-1:0] store_data;
        logic [`EXEC_XLEN-1:0] csr_value;
        logic [4:0]            rd;
        logic [3:0]            csr_wen;
        logic                  reg_wen;
        logic                  mem_wen;
        logic                  mem_ren;
    } operands_t;

endpackage

//--- hw/exec_config.svh
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// datapath width of the execute slice.
`define EXEC_XLEN 32

// input queue depth, also the producer's starting credits.
`define EXEC_IN_DEPTH 4

// output queue depth, also the credits the input queue starts with.
`define EXEC_OUT_DEPTH 4

// slots the memory stage grants at reset.
`define EXEC_CONS_CREDITS 2

`endif
